/* all.f */
hw/mips_pkg.sv
hw/decode_control.sv
hw/register_bank.sv
hw/decode.sv
hw/execute.sv
hw/memory_writeback.sv
hw/mips_core.sv
tests/tb_mips_core.sv

/* hw/decode.sv */
// decode stage: control, register read, sign extension
// and the id_ex pipeline register
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  logic             i_clk,
	input  logic             i_arst_n,
	input  logic             i_instr_valid,
	input  mips_pkg::instr_u i_instr,
	input  logic [31:0]      i_next_pc,
	input  mips_pkg::wb_t    i_wb,
	output mips_pkg::id_ex_t o_id_ex
);
	import mips_pkg::*;

	ctrl_t       ctrl;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] sign_ext;
	id_ex_t      id_ex_next;

	// ====================
	// submodules
	// ====================
	decode_control u_decode_control (
		.i_opcode (i_instr.r.op),
		.o_ctrl   (ctrl)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_rs_addr (i_instr.r.rs),
		.i_rt_addr (i_instr.r.rt),
		.i_wb      (i_wb),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	assign sign_ext = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};

	// ====================
	// id_ex register
	// ====================
	always_comb
	begin
		id_ex_next          = '0;
		id_ex_next.valid    = i_instr_valid;
		// bubble carries no control
		id_ex_next.ctrl     = i_instr_valid ? ctrl : '0;
		id_ex_next.next_pc  = i_next_pc;
		id_ex_next.rs_data  = rs_data;
		id_ex_next.rt_data  = rt_data;
		id_ex_next.sign_ext = sign_ext;
		id_ex_next.rt_addr  = i_instr.i.rt;
		id_ex_next.rd_addr  = i_instr.r.rd;
		id_ex_next.funct    = i_instr.r.funct;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_id_ex <= '0;
		else
			o_id_ex <= id_ex_next;
	end

endmodule

`default_nettype wire

/* hw/decode_control.sv */
// main control table, opcode to control bundle
`timescale 1ns/1ps
`default_nettype none

module decode_control (
	input  logic [5:0]      i_opcode,
	output mips_pkg::ctrl_t o_ctrl
);
	import mips_pkg::*;

	always_comb
	begin
		o_ctrl = '0;
		case (i_opcode)
			OP_RTYPE:
			begin
				o_ctrl.regdst   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_FUNCT;
			end
			OP_ADDI:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_LW:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.memread  = 1'b1;
				o_ctrl.memtoreg = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_SW:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.memwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_BEQ:
			begin
				o_ctrl.branch = 1'b1;
				o_ctrl.aluop  = ALUOP_SUB;
			end
			// anything else is a no-op
			default: o_ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/execute.sv */
// execute stage: alu control, alu, branch compare and target
// and the ex_mem pipeline register
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  mips_pkg::id_ex_t  i_id_ex,
	output mips_pkg::ex_mem_t o_ex_mem,
	output mips_pkg::branch_t o_branch
);
	import mips_pkg::*;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	logic        alu_ok;
	ex_mem_t     ex_mem_next;
	branch_t     branch_next;

	assign alu_a = i_id_ex.rs_data;
	assign alu_b = i_id_ex.ctrl.alusrc ? i_id_ex.sign_ext : i_id_ex.rt_data;

	// ====================
	// alu
	// ====================
	always_comb
	begin
		alu_y  = '0;
		alu_ok = 1'b1;
		case (i_id_ex.ctrl.aluop)
			ALUOP_ADD: alu_y = alu_a + alu_b;
			ALUOP_SUB: alu_y = alu_a - alu_b;
			ALUOP_FUNCT:
			begin
				case (i_id_ex.funct)
					FN_ADD:  alu_y = alu_a + alu_b;
					FN_SUB:  alu_y = alu_a - alu_b;
					FN_AND:  alu_y = alu_a & alu_b;
					FN_OR:   alu_y = alu_a | alu_b;
					FN_SLT:  alu_y = {31'd0, $signed(alu_a) < $signed(alu_b)};
					// unknown funct, treated as no-op
					default: alu_ok = 1'b0;
				endcase
			end
			default: alu_ok = 1'b0;
		endcase
	end

	always_comb
	begin
		ex_mem_next            = '0;
		ex_mem_next.valid      = i_id_ex.valid;
		ex_mem_next.memread    = i_id_ex.ctrl.memread;
		ex_mem_next.memwrite   = i_id_ex.ctrl.memwrite;
		ex_mem_next.memtoreg   = i_id_ex.ctrl.memtoreg;
		ex_mem_next.regwrite   = i_id_ex.ctrl.regwrite && alu_ok;
		ex_mem_next.alu_result = alu_y;
		ex_mem_next.store_data = i_id_ex.rt_data;
		ex_mem_next.dest       = i_id_ex.ctrl.regdst ? i_id_ex.rd_addr : i_id_ex.rt_addr;

		// beq compares through the subtract
		branch_next.valid  = i_id_ex.valid && i_id_ex.ctrl.branch;
		branch_next.taken  = branch_next.valid && (alu_y == 32'd0);
		branch_next.target = i_id_ex.next_pc + {i_id_ex.sign_ext[29:0], 2'b00};
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_ex_mem <= '0;
			o_branch <= '0;
		end
		else
		begin
			o_ex_mem <= ex_mem_next;
			o_branch <= branch_next;
		end
	end

endmodule

`default_nettype wire

/* hw/memory_writeback.sv */
// data memory stage with the writeback register
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  mips_pkg::ex_mem_t i_ex_mem,
	output mips_pkg::wb_t     o_wb
);
	import mips_pkg::*;

	logic [31:0]        dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0] dmem_addr;
	logic [31:0]        load_data;
	wb_t                wb_next;

	// word addressed
	assign dmem_addr = i_ex_mem.alu_result[DMEM_AW+1:2];
	assign load_data = i_ex_mem.memread ? dmem[dmem_addr] : 32'd0;

	// ====================
	// data ram
	// ====================
	always_ff @(posedge i_clk)
	begin
		if (i_ex_mem.valid && i_ex_mem.memwrite)
			dmem[dmem_addr] <= i_ex_mem.store_data;
	end

	// ====================
	// writeback
	// ====================
	always_comb
	begin
		wb_next.valid    = i_ex_mem.valid && i_ex_mem.regwrite && (i_ex_mem.dest != 5'd0);
		wb_next.reg_addr = i_ex_mem.dest;
		wb_next.data     = i_ex_mem.memtoreg ? load_data : i_ex_mem.alu_result;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_wb <= '0;
		else
			o_wb <= wb_next;
	end

endmodule

`default_nettype wire

/* hw/mips_core.sv */
// pipeline top: decode, execute, memory/writeback
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  logic              i_clk,
	input  logic              i_arst_n,
	input  logic              i_instr_valid,
	input  mips_pkg::instr_u  i_instr,
	input  logic [31:0]       i_next_pc,
	output mips_pkg::wb_t     o_wb,
	output mips_pkg::branch_t o_branch
);
	import mips_pkg::*;

	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	wb_t     wb;

	// ====================
	// stages
	// ====================
	decode u_decode (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_next_pc     (i_next_pc),
		.i_wb          (wb),
		.o_id_ex       (id_ex)
	);

	execute u_execute (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_id_ex  (id_ex),
		.o_ex_mem (ex_mem),
		.o_branch (o_branch)
	);

	// writeback feeds the register bank and the port
	memory_writeback u_memory_writeback (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_ex_mem (ex_mem),
		.o_wb     (wb)
	);

	assign o_wb = wb;

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
// shared encodings for the MIPS core
// opcode and funct values, instruction views, stage bundles
`default_nettype none

package mips_pkg;

	// ====================
	// encodings
	// ====================
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2B;
	localparam logic [5:0] OP_BEQ   = 6'h04;

	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2A;

	// alu operation class from the control table
	localparam logic [1:0] ALUOP_ADD   = 2'b00;
	localparam logic [1:0] ALUOP_SUB   = 2'b01;
	localparam logic [1:0] ALUOP_FUNCT = 2'b10;

	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// ====================
	// instruction views
	// ====================
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fields_t;

	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

	// ====================
	// stage bundles
	// ====================
	typedef struct packed {
		logic       regdst;
		logic       branch;
		logic       memread;
		logic       memtoreg;
		logic       memwrite;
		logic       alusrc;
		logic       regwrite;
		logic [1:0] aluop;
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] next_pc;
		logic [31:0] rs_data;
		logic [31:0] rt_data;
		logic [31:0] sign_ext;
		logic [4:0]  rt_addr;
		logic [4:0]  rd_addr;
		logic [5:0]  funct;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic        memread;
		logic        memwrite;
		logic        memtoreg;
		logic        regwrite;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0]  dest;
	} ex_mem_t;

	// register write, also the writeback report
	typedef struct packed {
		logic        valid;
		logic [4:0]  reg_addr;
		logic [31:0] data;
	} wb_t;

	typedef struct packed {
		logic        valid;
		logic        taken;
		logic [31:0] target;
	} branch_t;

endpackage

`default_nettype wire

/* hw/register_bank.sv */
// 32x32 register file, two read ports, one write port
// write data bypasses to the read ports in the same cycle
`timescale 1ns/1ps
`default_nettype none

module register_bank (
	input  logic          i_clk,
	input  logic          i_arst_n,
	input  logic [4:0]    i_rs_addr,
	input  logic [4:0]    i_rt_addr,
	input  mips_pkg::wb_t i_wb,
	output logic [31:0]   o_rs_data,
	output logic [31:0]   o_rt_data
);
	import mips_pkg::*;

	logic [31:0] regs [32];

	// one read port, with write-through and $zero
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		logic hit;
		hit = i_wb.valid && (i_wb.reg_addr == addr);
		if (addr == 5'd0)
			return '0;
		else if (hit)
			return i_wb.data;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_wb.valid && (i_wb.reg_addr != 5'd0))
		begin
			regs[i_wb.reg_addr] <= i_wb.data;
		end
	end

	assign o_rs_data = read_port(i_rs_addr);
	assign o_rt_data = read_port(i_rt_addr);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_mips_core -f all.f -o tb_mips_core \
	&& ./obj_dir/tb_mips_core \
	|| exit 1

/* tests/mips_stimulus.txt */
// instr next_pc kind exp1 exp2, kind 0 none, 1 writeback (exp1 reg, exp2 data)
// kind 2 taken, 3 not taken (exp2 target), +10 next line 3 cycles later, F end
00221820 00000004 1 00000003 00000000
20010005 00000008 1 00000001 00000005
2002FFFD 0000000C 1 00000002 FFFFFFFD
00222020 00000010 1 00000004 00000002
00222822 00000014 1 00000005 00000008
00223024 00000018 1 00000006 00000005
00223825 0000001C 1 00000007 FFFFFFFD
0041402A 00000020 1 00000008 00000001
0022482A 00000024 1 00000009 00000000
AC010008 00000028 0 00000000 00000000
AC02000C 0000002C 0 00000000 00000000
8C0A0008 00000030 1 0000000A 00000005
8C0B000C 00000034 1 0000000B FFFFFFFD
102A0003 00000038 2 00000000 00000044
10220003 0000003C 3 00000000 00000048
104BFFFC 00000040 2 00000000 00000030
20200007 00000044 0 00000000 00000000
FC221820 00000048 0 00000000 00000000
0022183F 0000004C 0 00000000 00000000
00006020 00000050 1 0000000C 00000000
200D0064 00000054 11 0000000D 00000064
01AD7020 00000058 11 0000000E 000000C8
21CFFF6A 0000005C 1 0000000F 00000032
00000000 00000000 F 00000000 00000000

/* tests/tb_mips_core.sv */
// testbench for the MIPS pipeline core
// issues instructions from the stimulus file, checks writebacks and branch reports
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;
	import mips_pkg::*;

	localparam int         MAX_LINES      = 48;
	localparam int         WORDS          = 5;
	localparam logic [3:0] KIND_NONE      = 4'h0;
	localparam logic [3:0] KIND_WB        = 4'h1;
	localparam logic [3:0] KIND_TAKEN     = 4'h2;
	localparam logic [3:0] KIND_NOT_TAKEN = 4'h3;
	// o_wb and o_branch latency in cycles after issue
	localparam int         WB_EDGES       = 3;
	localparam int         BRANCH_EDGES   = 2;

	logic        i_clk;
	logic        i_arst_n;
	logic        i_instr_valid;
	instr_u      i_instr;
	logic [31:0] i_next_pc;
	wb_t         o_wb;
	branch_t     o_branch;

	logic [31:0] stim [256];
	int          seed;
	int          line_count;

	mips_core DUT (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_next_pc     (i_next_pc),
		.o_wb          (o_wb),
		.o_branch      (o_branch)
	);

	always #5 i_clk = ~i_clk;

	// ====================
	// helpers
	// ====================
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "testbench stopped");
	endtask

	task automatic check_wb(input string name, input wb_t expected, input wb_t actual);
		if (actual !== expected)
			report_failure($sformatf("Fail %s: expected wb reg %0d data %h, actual reg %0d data %h",
				name, expected.reg_addr, expected.data, actual.reg_addr, actual.data));
	endtask

	task automatic check_branch(input string name, input branch_t expected, input branch_t actual);
		if (actual !== expected)
			report_failure($sformatf("Fail %s: expected taken %b target %h, actual taken %b target %h",
				name, expected.taken, expected.target, actual.taken, actual.target));
	endtask

	task automatic drive_idle();
		i_instr_valid = 1'b0;
		i_instr       = '0;
		i_next_pc     = '0;
	endtask

	// no result may show up in these cycles
	task automatic expect_quiet(input int cycles, input string where);
		for (int c = 0; c < cycles; c++)
		begin
			@(negedge i_clk);
			if (o_wb.valid || o_branch.valid)
				report_failure($sformatf("a result came out %s with nothing issued", where));
		end
	endtask

	// issue one line, then watch its window of idle cycles
	task automatic run_instr(input int idx);
		logic [7:0]  base;
		logic [31:0] kind_word;
		logic [3:0]  kind;
		wb_t         exp_wb;
		branch_t     exp_br;
		string       name;
		int          idle;
		int          edge_no;
		bit          seen;

		base      = 8'(idx * WORDS);
		kind_word = stim[base + 8'd2];
		kind      = kind_word[3:0];
		name      = $sformatf("line %0d instr %h", idx, stim[base]);
		if (kind > KIND_NOT_TAKEN)
			report_failure($sformatf("%s has an unknown result kind %h", name, kind_word));
		exp_wb.valid    = 1'b1;
		exp_wb.reg_addr = stim[base + 8'd3][4:0];
		exp_wb.data     = stim[base + 8'd4];
		exp_br.valid    = 1'b1;
		exp_br.taken    = (kind == KIND_TAKEN);
		exp_br.target   = stim[base + 8'd4];
		// bit 4 asks for the next line three cycles on, through the bypass
		if (kind_word[4])
			idle = 2;
		else
			idle = 3 + int'($unsigned($random(seed)) % 3);

		i_instr_valid = 1'b1;
		i_instr       = stim[base];
		i_next_pc     = stim[base + 8'd1];
		seen          = 1'b0;
		edge_no       = 0;
		while (edge_no < idle + 1)
		begin
			@(negedge i_clk);
			edge_no++;
			if (o_wb.valid)
			begin
				if (kind != KIND_WB || edge_no != WB_EDGES)
					report_failure($sformatf("unexpected writeback to reg %0d, %0d cycles after %s",
						o_wb.reg_addr, edge_no, name));
				else
				begin
					check_wb(name, exp_wb, o_wb);
					seen = 1'b1;
				end
			end
			if (o_branch.valid)
			begin
				if ((kind != KIND_TAKEN && kind != KIND_NOT_TAKEN) || edge_no != BRANCH_EDGES)
					report_failure($sformatf("unexpected branch report %0d cycles after %s",
						edge_no, name));
				else
				begin
					check_branch(name, exp_br, o_branch);
					seen = 1'b1;
				end
			end
			drive_idle();
		end
		if (kind != KIND_NONE && !seen)
			report_failure($sformatf("%s timed out with no result at the ports", name));
	endtask

	// ====================
	// main sequence
	// ====================
	initial
	begin
		seed     = 31853;
		i_clk    = 1'b0;
		i_arst_n = 1'b0;
		drive_idle();
		$readmemh("tests/mips_stimulus.txt", stim);

		repeat (16) @(negedge i_clk);
		if (o_wb.valid || o_branch.valid)
			report_failure("a result was valid while reset was held");
		i_arst_n = 1'b1;
		expect_quiet(4, "after reset");

		line_count = 0;
		while (line_count < MAX_LINES && stim[8'(line_count * WORDS + 2)] !== 32'h0000000F)
		begin
			run_instr(line_count);
			line_count++;
		end
		if (line_count == MAX_LINES)
			report_failure("the stimulus file has no end marker");
		expect_quiet(4, "after the last instruction");

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
